// ==== verilog/synth_pkg.sv ====
package synth_pkg;

    localparam int num_voices = 4;
    localparam int midi_w     = 7;
    localparam int sample_w   = 8;
    localparam int phase_w    = 16;

    // the fourth code is decoded as saw.
    typedef enum logic [1:0] {
        wave_saw      = 2'd0,
        wave_square   = 2'd1,
        wave_triangle = 2'd2
    } waveform_t;

    localparam logic [midi_w-1:0] cc_waveform     = 7'd70;
    localparam logic [midi_w-1:0] cc_square_min   = 7'd43;
    localparam logic [midi_w-1:0] cc_triangle_min = 7'd86;

    // base table is octave 10 (notes 120..131), lower octaves shift right.
    function automatic logic [phase_w-1:0] note_incr(input logic [midi_w-1:0] note);
        logic [3:0]         octave;
        logic [3:0]         semi;
        logic [phase_w-1:0] base;
        octave = 4'(note / 7'd12);
        semi   = 4'(note % 7'd12);
        case (semi)
            4'd0:    base = 16'd16384;
            4'd1:    base = 16'd17358;
            4'd2:    base = 16'd18391;
            4'd3:    base = 16'd19484;
            4'd4:    base = 16'd20643;
            4'd5:    base = 16'd21870;
            4'd6:    base = 16'd23170;
            4'd7:    base = 16'd24548;
            4'd8:    base = 16'd26008;
            4'd9:    base = 16'd27554;
            4'd10:   base = 16'd29193;
            default: base = 16'd30929;
        endcase
        return base >> (4'd10 - octave);
    endfunction

endpackage

// ==== verilog/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx #(
    parameter int clks_per_bit = 8
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       di,
    output logic [7:0] byte_data,
    output logic       byte_valid
);

    localparam int cnt_w = $clog2(clks_per_bit);
    localparam logic [cnt_w-1:0] cnt_full = cnt_w'(clks_per_bit - 1);
    localparam logic [cnt_w-1:0] cnt_half = cnt_w'(clks_per_bit / 2 - 1);

    typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} state_t;

    state_t           state;
    logic [cnt_w-1:0] cnt;
    logic [2:0]       bit_idx;
    logic [1:0]       di_sync;
    logic [7:0]       shift;
    logic             rx;
    logic             take_bit;

    assign rx        = di_sync[1];
    assign take_bit  = (state == st_data) && (cnt == cnt_full);
    assign byte_data = shift;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= st_idle;
            cnt        <= '0;
            bit_idx    <= '0;
            di_sync    <= 2'b11;
            byte_valid <= 1'b0;
        end else begin
            di_sync    <= {di_sync[0], di};
            byte_valid <= 1'b0;
            case (state)
                st_idle: begin
                    cnt <= '0;
                    if (!rx) state <= st_start;
                end
                st_start: begin
                    if (cnt == cnt_half) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        // a start bit gone high by mid-bit was a glitch.
                        state   <= rx ? st_idle : st_data;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                st_data: begin
                    if (take_bit) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= st_stop;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    if (cnt == cnt_full) begin
                        byte_valid <= rx;
                        state      <= st_idle;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // lsb first.
    always_ff @(posedge clk) begin
        if (take_bit) shift <= {rx, shift[7:1]};
    end

    a_byte_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        byte_valid |=> !byte_valid);

endmodule

// ==== verilog/midi_parser.sv ====
`timescale 1ns/1ps

module midi_parser (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [3:0]                  channel,
    input  logic [7:0]                  byte_data,
    input  logic                        byte_valid,
    output logic [synth_pkg::midi_w-1:0] note_num,
    output logic [synth_pkg::midi_w-1:0] note_vel,
    output logic [synth_pkg::midi_w-1:0] cc_num,
    output logic [synth_pkg::midi_w-1:0] cc_val,
    output logic                        note_on,
    output logic                        note_off,
    output logic                        cc_valid
);

    import synth_pkg::*;

    typedef enum logic [1:0] {rs_none, rs_note_on, rs_note_off, rs_cc} run_t;

    run_t              run;
    logic              have_first;
    logic [midi_w-1:0] first_byte;
    logic              is_status;
    logic              is_data;

    // real-time bytes fall in neither class.
    assign is_status = byte_valid && byte_data[7] && (byte_data < 8'hF8);
    assign is_data   = byte_valid && !byte_data[7] && (run != rs_none);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run        <= rs_none;
            have_first <= 1'b0;
            note_on    <= 1'b0;
            note_off   <= 1'b0;
            cc_valid   <= 1'b0;
        end else begin
            note_on  <= 1'b0;
            note_off <= 1'b0;
            cc_valid <= 1'b0;
            if (is_status) begin
                have_first <= 1'b0;
                if (byte_data[3:0] != channel) begin
                    run <= rs_none;
                end else begin
                    case (byte_data[7:4])
                        4'h9:    run <= rs_note_on;
                        4'h8:    run <= rs_note_off;
                        4'hB:    run <= rs_cc;
                        default: run <= rs_none;
                    endcase
                end
            end else if (is_data) begin
                have_first <= !have_first;
                if (have_first) begin
                    case (run)
                        rs_note_on: begin
                            // velocity 0 means release.
                            note_on  <= (byte_data[6:0] != '0);
                            note_off <= (byte_data[6:0] == '0);
                        end
                        rs_note_off: note_off <= 1'b1;
                        default:     cc_valid <= 1'b1;
                    endcase
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (is_data && !have_first) first_byte <= byte_data[6:0];
        if (is_data && have_first) begin
            note_num <= first_byte;
            note_vel <= byte_data[6:0];
            cc_num   <= first_byte;
            cc_val   <= byte_data[6:0];
        end
    end

endmodule

// ==== verilog/voice_alloc.sv ====
`timescale 1ns/1ps

module voice_alloc (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [synth_pkg::midi_w-1:0]     note_num,
    input  logic [synth_pkg::midi_w-1:0]     note_vel,
    input  logic                            note_on,
    input  logic                            note_off,
    output logic [synth_pkg::midi_w-1:0]     voice_note [synth_pkg::num_voices],
    output logic [synth_pkg::midi_w-1:0]     voice_vel  [synth_pkg::num_voices],
    output logic [synth_pkg::num_voices-1:0] voice_active
);

    import synth_pkg::*;

    localparam int idx_w = $clog2(num_voices);

    logic [idx_w-1:0] free_idx;
    logic             free_found;
    logic [idx_w-1:0] off_idx;
    logic             off_found;

    // scan downwards so the lowest match wins.
    always_comb begin
        free_idx   = '0;
        free_found = 1'b0;
        off_idx    = '0;
        off_found  = 1'b0;
        for (int i = num_voices - 1; i >= 0; i--) begin
            if (!voice_active[i]) begin
                free_idx   = idx_w'(i);
                free_found = 1'b1;
            end
            if (voice_active[i] && (voice_note[i] == note_num)) begin
                off_idx   = idx_w'(i);
                off_found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            voice_active <= '0;
        end else if (note_on && free_found) begin
            voice_active[free_idx] <= 1'b1;
        end else if (note_off && off_found) begin
            voice_active[off_idx] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (note_on && free_found) begin
            voice_note[free_idx] <= note_num;
            voice_vel[free_idx]  <= note_vel;
        end
    end

    a_on_off_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(note_on && note_off));

endmodule

// ==== verilog/synth_ctrl_regs.sv ====
`timescale 1ns/1ps

module synth_ctrl_regs (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [synth_pkg::midi_w-1:0] cc_num,
    input  logic [synth_pkg::midi_w-1:0] cc_val,
    input  logic                        cc_valid,
    output synth_pkg::waveform_t        waveform
);

    import synth_pkg::*;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            waveform <= wave_saw;
        end else if (cc_valid && (cc_num == cc_waveform)) begin
            if (cc_val >= cc_triangle_min) begin
                waveform <= wave_triangle;
            end else if (cc_val >= cc_square_min) begin
                waveform <= wave_square;
            end else begin
                waveform <= wave_saw;
            end
        end
    end

endmodule

// ==== verilog/osc_bank.sv ====
`timescale 1ns/1ps

module osc_bank #(
    parameter int sample_div = 64
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [synth_pkg::midi_w-1:0]     voice_note [synth_pkg::num_voices],
    input  logic [synth_pkg::midi_w-1:0]     voice_vel  [synth_pkg::num_voices],
    input  logic [synth_pkg::num_voices-1:0] voice_active,
    input  synth_pkg::waveform_t            waveform,
    output logic [synth_pkg::sample_w-1:0]   voice_sample [synth_pkg::num_voices],
    output logic                            sample_tick
);

    import synth_pkg::*;

    localparam int div_w = $clog2(sample_div);
    localparam logic [div_w-1:0] div_last = div_w'(sample_div - 1);

    logic [div_w-1:0]    div_cnt;
    logic [phase_w-1:0]  phase  [num_voices];
    logic [sample_w-1:0] scaled [num_voices];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_cnt     <= '0;
            sample_tick <= 1'b0;
        end else begin
            div_cnt     <= (div_cnt == div_last) ? '0 : div_cnt + 1'b1;
            sample_tick <= (div_cnt == div_last);
        end
    end

    always_comb begin
        logic [sample_w-1:0]        top;
        logic [sample_w-1:0]        shaped;
        logic [sample_w+midi_w-1:0] prod;
        for (int v = 0; v < num_voices; v++) begin
            top = phase[v][phase_w-1 -: sample_w];
            case (waveform)
                wave_square:   shaped = {sample_w{top[sample_w-1]}};
                // second half runs back down.
                wave_triangle: shaped = top[sample_w-1] ? {~top[sample_w-2:0], 1'b0}
                                                        : {top[sample_w-2:0], 1'b0};
                default:       shaped = top;
            endcase
            prod      = shaped * voice_vel[v];
            scaled[v] = prod[midi_w +: sample_w];
        end
    end

    // an idle voice sits at phase 0, so every new note starts from zero.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int v = 0; v < num_voices; v++) begin
                phase[v]        <= '0;
                voice_sample[v] <= '0;
            end
        end else begin
            for (int v = 0; v < num_voices; v++) begin
                if (!voice_active[v]) begin
                    phase[v]        <= '0;
                    voice_sample[v] <= '0;
                end else if (sample_tick) begin
                    phase[v]        <= phase[v] + note_incr(voice_note[v]);
                    voice_sample[v] <= scaled[v];
                end
            end
        end
    end

endmodule

// ==== verilog/mixer.sv ====
`timescale 1ns/1ps

module mixer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [synth_pkg::sample_w-1:0] voice_sample [synth_pkg::num_voices],
    input  logic                          sample_tick,
    input  logic                          sample_ready,
    output logic [synth_pkg::sample_w-1:0] sample,
    output logic                          sample_valid
);

    import synth_pkg::*;

    localparam int sum_w = sample_w + $clog2(num_voices);

    logic [sum_w-1:0] sum;
    logic             load;

    always_comb begin
        sum = '0;
        for (int v = 0; v < num_voices; v++) begin
            sum = sum + sum_w'(voice_sample[v]);
        end
    end

    // a tick during a stalled transfer is dropped.
    assign load = sample_tick && (!sample_valid || sample_ready);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sample_valid <= 1'b0;
        end else if (load) begin
            sample_valid <= 1'b1;
        end else if (sample_ready) begin
            sample_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) sample <= sum[sum_w-1 -: sample_w];
    end

    a_hold_pending: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid && !sample_ready |=> sample_valid && $stable(sample));

endmodule

// ==== verilog/synth_top.sv ====
`timescale 1ns/1ps

module synth_top #(
    parameter int clks_per_bit = 8,
    parameter int sample_div   = 64
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            di,
    input  logic [3:0]                      channel,
    output logic [synth_pkg::sample_w-1:0]   sample,
    output logic                            sample_valid,
    input  logic                            sample_ready,
    output logic [synth_pkg::num_voices-1:0] voice_active
);

    import synth_pkg::*;

    logic [7:0]          byte_data;
    logic                byte_valid;
    logic [midi_w-1:0]   note_num;
    logic [midi_w-1:0]   note_vel;
    logic [midi_w-1:0]   cc_num;
    logic [midi_w-1:0]   cc_val;
    logic                note_on;
    logic                note_off;
    logic                cc_valid;
    logic [midi_w-1:0]   voice_note   [num_voices];
    logic [midi_w-1:0]   voice_vel    [num_voices];
    logic [sample_w-1:0] voice_sample [num_voices];
    logic                sample_tick;
    waveform_t           waveform;

    uart_rx #(
        .clks_per_bit(clks_per_bit)
    ) i_uart_rx (
        .clk(clk), .rst_n(rst_n), .di(di),
        .byte_data(byte_data), .byte_valid(byte_valid)
    );

    midi_parser i_midi_parser (
        .clk(clk), .rst_n(rst_n), .channel(channel),
        .byte_data(byte_data), .byte_valid(byte_valid),
        .note_num(note_num), .note_vel(note_vel),
        .cc_num(cc_num), .cc_val(cc_val),
        .note_on(note_on), .note_off(note_off), .cc_valid(cc_valid)
    );

    voice_alloc i_voice_alloc (
        .clk(clk), .rst_n(rst_n),
        .note_num(note_num), .note_vel(note_vel),
        .note_on(note_on), .note_off(note_off),
        .voice_note(voice_note), .voice_vel(voice_vel), .voice_active(voice_active)
    );

    synth_ctrl_regs i_synth_ctrl_regs (
        .clk(clk), .rst_n(rst_n),
        .cc_num(cc_num), .cc_val(cc_val), .cc_valid(cc_valid),
        .waveform(waveform)
    );

    osc_bank #(
        .sample_div(sample_div)
    ) i_osc_bank (
        .clk(clk), .rst_n(rst_n),
        .voice_note(voice_note), .voice_vel(voice_vel), .voice_active(voice_active),
        .waveform(waveform),
        .voice_sample(voice_sample), .sample_tick(sample_tick)
    );

    mixer i_mixer (
        .clk(clk), .rst_n(rst_n),
        .voice_sample(voice_sample), .sample_tick(sample_tick),
        .sample_ready(sample_ready), .sample(sample), .sample_valid(sample_valid)
    );

endmodule

// ==== verification/synth_tb.sv ====
`timescale 1ns/1ps

module synth_tb;

    import synth_pkg::*;

    localparam int clks_per_bit = 8;
    localparam int sample_div   = 64;

    localparam int mode_none   = 0;
    localparam int mode_square = 1;
    localparam int mode_saw    = 2;
    localparam int mode_silent = 3;

    logic        clk;
    logic        rst_n;
    logic        di;
    logic [3:0]  channel;
    logic [7:0]  sample;
    logic        sample_valid;
    logic        sample_ready;
    logic [3:0]  voice_active;

    logic [31:0] lfsr;
    int          checks;
    int          errors;
    int          test_base;
    int          accepted;
    int          mode;
    bit          settled;
    bit          hold_pend;
    logic [7:0]  held;
    int          prev_s;
    bit          have_prev;
    int          n_lo;
    int          n_hi;

    // expected voice table and waveform.
    logic [6:0]  exp_note [4];
    logic [6:0]  exp_vel  [4];
    logic [3:0]  exp_active;
    waveform_t   exp_wave;

    synth_top #(
        .clks_per_bit(clks_per_bit),
        .sample_div(sample_div)
    ) i_synth_top (
        .clk(clk), .rst_n(rst_n), .di(di), .channel(channel),
        .sample(sample), .sample_valid(sample_valid), .sample_ready(sample_ready),
        .voice_active(voice_active)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        // taps 32, 22, 2, 1.
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one voice alone, velocity scaled, then divided by the voice count.
    function automatic int single_voice_sample(input waveform_t wave, input int top,
                                               input int vel);
        int shaped;
        case (wave)
            wave_square:   shaped = (top >= 128) ? 255 : 0;
            wave_triangle: shaped = (top < 128) ? 2 * top : 2 * (255 - top);
            default:       shaped = top;
        endcase
        return ((shaped * vel) >> 7) / 4;
    endfunction

    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic model_on(input int note, input int vel);
        for (int i = 0; i < 4; i++) begin
            if (!exp_active[i]) begin
                exp_active[i] = 1'b1;
                exp_note[i]   = 7'(note);
                exp_vel[i]    = 7'(vel);
                return;
            end
        end
    endtask

    task automatic model_off(input int note);
        for (int i = 0; i < 4; i++) begin
            if (exp_active[i] && exp_note[i] == 7'(note)) begin
                exp_active[i] = 1'b0;
                return;
            end
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        logic [11:0] frame;
        // start bit, data lsb first, stop bit and two idle bits.
        frame = {3'b111, b, 1'b0};
        for (int i = 0; i < 12; i++) begin
            for (int c = 0; c < clks_per_bit; c++) begin
                @(posedge clk);
                di <= frame[i];
            end
        end
    endtask

    task automatic begin_step();
        @(negedge clk);
        settled = 1'b0;
    endtask

    task automatic step_done();
        int n;
        n = 0;
        @(negedge clk);
        while (voice_active !== exp_active && n < 200) begin
            @(negedge clk);
            n++;
        end
        compare("voice_active", 32'(voice_active), 32'(exp_active));
        settled = 1'b1;
    endtask

    task automatic play_note(input bit with_status, input int note, input int vel);
        begin_step();
        if (with_status) send_byte(8'h93);
        send_byte(8'(note));
        send_byte(8'(vel));
        if (vel == 0) model_off(note);
        else model_on(note, vel);
        step_done();
    endtask

    task automatic set_waveform(input int value);
        begin_step();
        send_byte(8'hB3);
        send_byte(8'd70);
        send_byte(8'(value));
        if (value <= 42) exp_wave = wave_saw;
        else if (value <= 85) exp_wave = wave_square;
        else exp_wave = wave_triangle;
        step_done();
    endtask

    task automatic wait_samples(input int n);
        int target;
        int cycles;
        target = accepted + n;
        cycles = 0;
        while (accepted < target && cycles < n * sample_div * 4) begin
            @(negedge clk);
            cycles++;
        end
        if (accepted < target) begin
            errors++;
            $display("timeout: only %0d of %0d samples accepted", n - (target - accepted), n);
        end
    endtask

    task automatic set_mode(input int m);
        @(negedge clk);
        mode      = m;
        have_prev = 1'b0;
        n_lo      = 0;
        n_hi      = 0;
    endtask

    task automatic end_test(input string name);
        $display("test %-16s %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    task automatic judge_sample(input int s);
        int lo;
        int hi;
        int lim;
        lo = single_voice_sample(exp_wave, 0, int'(exp_vel[0]));
        hi = single_voice_sample(exp_wave, 255, int'(exp_vel[0]));
        case (mode)
            mode_square: begin
                if (s == lo) n_lo++;
                if (s == hi) n_hi++;
                compare("sample", 32'(s), 32'((s == lo) ? lo : hi));
            end
            mode_saw: begin
                lim = (s > hi) ? hi : s;
                // a drop from the upper half into the lower half is a wrap.
                if (have_prev && s < prev_s && !(prev_s > hi / 2 && s <= hi / 2)) lim = prev_s;
                compare("sample", 32'(s), 32'(lim));
            end
            mode_silent: compare("sample", 32'(s), 32'd0);
            default: ;
        endcase
        prev_s    = s;
        have_prev = 1'b1;
    endtask

    // ready from one lfsr bit per cycle.
    always @(posedge clk) begin
        lfsr = lfsr_next(lfsr);
        sample_ready <= lfsr[0];
    end

    always @(posedge clk) begin
        if (rst_n) begin
            if (hold_pend) begin
                compare("sample_valid", 32'(sample_valid), 32'd1);
                compare("sample", 32'(sample), 32'(held));
            end
            hold_pend = sample_valid && !sample_ready;
            held      = sample;
            if (sample_valid && sample_ready) begin
                accepted++;
                judge_sample(int'(sample));
                if (settled) compare("voice_active", 32'(voice_active), 32'(exp_active));
            end
        end
    end

    initial begin
        rst_n        = 1'b0;
        di           = 1'b1;
        channel      = 4'd3;
        sample_ready = 1'b0;
        lfsr         = 32'h6c06;
        checks       = 0;
        errors       = 0;
        test_base    = 0;
        accepted     = 0;
        mode         = mode_none;
        settled      = 1'b0;
        hold_pend    = 1'b0;
        have_prev    = 1'b0;
        exp_active   = '0;
        exp_wave     = wave_saw;
        for (int i = 0; i < 4; i++) begin
            exp_note[i] = '0;
            exp_vel[i]  = '0;
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        play_note(1, 60, 100);
        play_note(0, 62, 100);
        play_note(0, 64, 100);
        play_note(0, 67, 100);
        play_note(0, 72, 100);
        end_test("allocation");

        play_note(0, 62, 0);
        play_note(0, 64, 0);
        // voices 1 and 2 are free, the lower one is taken.
        play_note(0, 65, 90);
        end_test("release");

        play_note(0, 60, 0);
        begin_step();
        send_byte(8'h95);
        send_byte(8'd70);
        send_byte(8'd100);
        step_done();
        // a real-time byte after the first data byte completes nothing.
        begin_step();
        send_byte(8'h93);
        send_byte(8'd72);
        send_byte(8'hFE);
        step_done();
        // voice 0 is free again and takes this one.
        begin_step();
        send_byte(8'hF8);
        send_byte(8'd100);
        model_on(72, 100);
        step_done();
        end_test("channel filter");

        play_note(0, 72, 0);
        play_note(0, 65, 0);
        play_note(0, 67, 0);
        play_note(0, 84, 127);
        set_waveform(60);
        wait_samples(3);
        set_mode(mode_square);
        wait_samples(40);
        if (n_lo == 0 || n_hi == 0) begin
            errors++;
            $display("square output did not reach both levels");
        end
        set_mode(mode_none);
        end_test("square");

        play_note(1, 84, 0);
        play_note(0, 84, 100);
        set_waveform(10);
        wait_samples(3);
        set_mode(mode_saw);
        wait_samples(40);
        set_mode(mode_none);
        end_test("saw");

        play_note(1, 84, 0);
        wait_samples(3);
        set_mode(mode_silent);
        wait_samples(10);
        set_mode(mode_none);
        end_test("silence");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
verilog/synth_pkg.sv
verilog/uart_rx.sv
verilog/midi_parser.sv
verilog/voice_alloc.sv
verilog/synth_ctrl_regs.sv
verilog/osc_bank.sv
verilog/mixer.sv
verilog/synth_top.sv
verification/synth_tb.sv

// ==== Makefile ====
SIM := obj_dir/Vsynth_tb

all: run

$(SIM): build.f $(wildcard verilog/*.sv) $(wildcard verification/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module synth_tb \
		-f build.f -o Vsynth_tb

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
